/* hw/serial_read_pkg.sv */
// -------------------------------------------------
// Serial read engine shared definitions
// Widths, address and count types, the read
// request record and the sequencer states
// -------------------------------------------------

package serial_read_pkg;

    localparam int ADDR_W  = 32;
    localparam int COUNT_W = 32;
    localparam int ID_W    = 8;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [COUNT_W-1:0] count_t;
    typedef logic [ID_W-1:0]    engine_id_t;

    // One memory read request with the engine tag in the top bits
    typedef struct packed {
        engine_id_t cu_id;
        addr_t      base_address;
        count_t     address_offset;
    } read_req_t;

    typedef enum logic [2:0] {
        RESET,
        IDLE,
        SETUP,
        START,
        BUSY,
        PAUSE,
        DONE
    } seq_state_e;

endpackage

/* hw/read_config_if.sv */
// -------------------------------------------------
// Config path from the descriptor latch to the
// sequencer, with the sequencer idle flag going back
// -------------------------------------------------
`timescale 1ns/100ps

interface read_config_if;
    import serial_read_pkg::*;

    // Frozen read descriptor
    addr_t  array_pointer;
    count_t start_read;
    count_t end_read;
    count_t stride;

    logic config_ok;
    logic start_req;
    logic seq_idle;

    modport latch (
        output array_pointer, start_read, end_read, stride,
        output config_ok, start_req,
        input  seq_idle
    );

    modport sequencer (
        input  array_pointer, start_read, end_read, stride,
        input  config_ok, start_req,
        output seq_idle
    );

endinterface

/* hw/read_config_latch.sv */
// -------------------------------------------------
// Descriptor latch (decode stage)
// Registers the start request, snapshots the read
// descriptor while the sequencer is idle and marks
// descriptors with a zero stride as unusable
// -------------------------------------------------
`timescale 1ns/100ps

module read_config_latch (
    input  logic                    ap_clk,
    input  logic                    engine_areset,
    input  logic                    cfg_valid,
    input  serial_read_pkg::addr_t  cfg_array_pointer,
    input  serial_read_pkg::count_t cfg_start_read,
    input  serial_read_pkg::count_t cfg_end_read,
    input  serial_read_pkg::count_t cfg_stride,
    input  logic                    start,
    read_config_if.latch            cfg
);
    import serial_read_pkg::*;

    logic take_snapshot;

    // Only sample while idle with no start pending,
    // so the descriptor stays fixed from start request to done
    assign take_snapshot = cfg_valid && cfg.seq_idle && !cfg.start_req;

    // -------------------------------------------------
    // Start request and descriptor check
    // -------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (engine_areset) begin
            cfg.start_req <= 1'b0;
            cfg.config_ok <= 1'b0;
        end else begin
            cfg.start_req <= cfg_valid && start;
            if (take_snapshot) begin
                // Zero stride would never reach the end offset
                cfg.config_ok <= (cfg_stride != '0);
            end
        end
    end

    // -------------------------------------------------
    // Descriptor snapshot
    // -------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (take_snapshot) begin
            cfg.array_pointer <= cfg_array_pointer;
            cfg.start_read    <= cfg_start_read;
            cfg.end_read      <= cfg_end_read;
            cfg.stride        <= cfg_stride;
        end
    end

endmodule

/* hw/read_sequencer.sv */
// -------------------------------------------------
// Read sequencer (execute stage)
// Walks the offset counter from start_read up by
// stride and writes one read request per offset
// below end_read, pausing on FIFO near-full
// -------------------------------------------------
`timescale 1ns/100ps

module read_sequencer #(
    parameter serial_read_pkg::engine_id_t ENGINE_ID = '0
) (
    input  logic                       ap_clk,
    input  logic                       engine_areset,
    read_config_if.sequencer           cfg,
    input  logic                       prog_full,
    output logic                       wr_en,
    output serial_read_pkg::read_req_t wr_data,
    output logic                       ready,
    output logic                       done,
    output logic                       pause
);
    import serial_read_pkg::*;

    seq_state_e state;
    seq_state_e next_state;

    logic prog_full_reg;

    // One extra bit so a step past the top of the range still ends the run
    logic [COUNT_W:0] offset_count;
    logic             offset_live;
    logic             write_now;

    assign offset_live = offset_count < {1'b0, cfg.end_read};
    assign write_now   = (state == BUSY) && offset_live && !prog_full_reg;

    assign cfg.seq_idle = (state == IDLE);

    // -------------------------------------------------
    // State register
    // -------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (engine_areset) begin
            state         <= RESET;
            prog_full_reg <= 1'b0;
        end else begin
            state         <= next_state;
            prog_full_reg <= prog_full;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            RESET: begin
                next_state = IDLE;
            end
            IDLE: begin
                if (cfg.start_req) begin
                    // Bad descriptor ends the run with no requests
                    next_state = cfg.config_ok ? SETUP : DONE;
                end
            end
            SETUP: begin
                next_state = START;
            end
            START: begin
                next_state = BUSY;
            end
            BUSY: begin
                if (!offset_live) begin
                    next_state = DONE;
                end else if (prog_full_reg) begin
                    next_state = PAUSE;
                end
            end
            PAUSE: begin
                if (!prog_full_reg) begin
                    next_state = BUSY;
                end
            end
            DONE: begin
                // Hold done until the start request drops
                if (!cfg.start_req) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = RESET;
            end
        endcase
    end

    // -------------------------------------------------
    // Status and write strobe
    // -------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (engine_areset) begin
            wr_en <= 1'b0;
            ready <= 1'b0;
            done  <= 1'b0;
            pause <= 1'b0;
        end else begin
            wr_en <= write_now;
            ready <= (next_state == IDLE);
            done  <= (next_state == DONE);
            pause <= (next_state == PAUSE);
        end
    end

    // -------------------------------------------------
    // Offset counter and request payload
    // -------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (state == SETUP) begin
            offset_count <= {1'b0, cfg.start_read};
        end else if (write_now) begin
            offset_count <= offset_count + {1'b0, cfg.stride};
        end
    end

    always_ff @(posedge ap_clk) begin
        if (write_now) begin
            wr_data.cu_id          <= ENGINE_ID;
            wr_data.base_address   <= cfg.array_pointer;
            wr_data.address_offset <= offset_count[COUNT_W-1:0];
        end
    end

endmodule

/* hw/request_fifo.sv */
// -------------------------------------------------
// Request FIFO (result stage)
// Show-ahead circular buffer of read requests with
// a programmable near-full level
// -------------------------------------------------
`timescale 1ns/100ps

module request_fifo #(
    parameter int FIFO_DEPTH       = 32,
    parameter int PROG_FULL_MARGIN = 4
) (
    input  logic                       ap_clk,
    input  logic                       engine_areset,
    input  logic                       wr_en,
    input  serial_read_pkg::read_req_t wr_data,
    input  logic                       rd_en,
    output serial_read_pkg::read_req_t rd_data,
    output logic                       empty,
    output logic                       prog_full
);
    import serial_read_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    localparam logic [PTR_W-1:0] LAST_SLOT  = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(FIFO_DEPTH);
    // Occupancy at which free entries drop to the margin
    localparam logic [CNT_W-1:0] PROG_LEVEL = CNT_W'(FIFO_DEPTH - PROG_FULL_MARGIN);

    read_req_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic do_write;
    logic do_read;

    assign do_write = wr_en && (count != FULL_COUNT);
    assign do_read  = rd_en && !empty;

    // Head word shown before the pop
    assign rd_data   = mem[rd_ptr];
    assign empty     = (count == '0);
    assign prog_full = (count >= PROG_LEVEL);

    // -------------------------------------------------
    // Pointers and occupancy
    // -------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (engine_areset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge ap_clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

/* hw/serial_read_engine.sv */
// -------------------------------------------------
// Serial read engine top level
// Descriptor latch, sequencer and request FIFO,
// with requests flattened to plain ports
// -------------------------------------------------
`timescale 1ns/100ps

module serial_read_engine #(
    parameter int                          FIFO_DEPTH       = 32,
    parameter int                          PROG_FULL_MARGIN = 4,
    parameter serial_read_pkg::engine_id_t ENGINE_ID        = '0
) (
    input  logic                        ap_clk,
    input  logic                        engine_areset,
    input  logic                        cfg_valid,
    input  serial_read_pkg::addr_t      cfg_array_pointer,
    input  serial_read_pkg::count_t     cfg_start_read,
    input  serial_read_pkg::count_t     cfg_end_read,
    input  serial_read_pkg::count_t     cfg_stride,
    input  logic                        start,
    output logic                        ready,
    output logic                        done,
    output logic                        pause,
    output logic                        req_valid,
    input  logic                        req_pop,
    output serial_read_pkg::engine_id_t req_cu_id,
    output serial_read_pkg::addr_t      req_base_address,
    output serial_read_pkg::count_t     req_address_offset
);
    import serial_read_pkg::*;

    read_config_if cfg_bus ();

    logic      wr_en;
    read_req_t wr_data;
    read_req_t rd_data;
    logic      fifo_empty;
    logic      prog_full;

    assign req_valid          = !fifo_empty;
    assign req_cu_id          = rd_data.cu_id;
    assign req_base_address   = rd_data.base_address;
    assign req_address_offset = rd_data.address_offset;

    read_config_latch u_latch (
        .ap_clk            (ap_clk),
        .engine_areset     (engine_areset),
        .cfg_valid         (cfg_valid),
        .cfg_array_pointer (cfg_array_pointer),
        .cfg_start_read    (cfg_start_read),
        .cfg_end_read      (cfg_end_read),
        .cfg_stride        (cfg_stride),
        .start             (start),
        .cfg               (cfg_bus.latch)
    );

    read_sequencer #(
        .ENGINE_ID (ENGINE_ID)
    ) u_sequencer (
        .ap_clk        (ap_clk),
        .engine_areset (engine_areset),
        .cfg           (cfg_bus.sequencer),
        .prog_full     (prog_full),
        .wr_en         (wr_en),
        .wr_data       (wr_data),
        .ready         (ready),
        .done          (done),
        .pause         (pause)
    );

    // Pops on an empty FIFO are dropped inside
    request_fifo #(
        .FIFO_DEPTH       (FIFO_DEPTH),
        .PROG_FULL_MARGIN (PROG_FULL_MARGIN)
    ) u_fifo (
        .ap_clk        (ap_clk),
        .engine_areset (engine_areset),
        .wr_en         (wr_en),
        .wr_data       (wr_data),
        .rd_en         (req_pop),
        .rd_data       (rd_data),
        .empty         (fifo_empty),
        .prog_full     (prog_full)
    );

endmodule

/* bench/serial_read_engine_tb.sv */
// -------------------------------------------------
// Testbench for the serial read engine
// LCG descriptors, a reference model of the offset
// walk and a consumer that pops and checks requests
// -------------------------------------------------
`timescale 1ns/100ps

module serial_read_engine_tb;
    import serial_read_pkg::*;

    localparam int         NUM_TESTS    = 7;
    localparam engine_id_t TB_ENGINE_ID = 8'h5a;

    logic       ap_clk = 1'b0;
    logic       engine_areset;
    logic       cfg_valid;
    addr_t      cfg_array_pointer;
    count_t     cfg_start_read;
    count_t     cfg_end_read;
    count_t     cfg_stride;
    logic       start;
    logic       ready;
    logic       done;
    logic       pause;
    logic       req_valid;
    logic       req_pop;
    engine_id_t req_cu_id;
    addr_t      req_base_address;
    count_t     req_address_offset;

    // Descriptors for each test are filled before reset
    addr_t  t_ptr    [NUM_TESTS];
    count_t t_start  [NUM_TESTS];
    count_t t_end    [NUM_TESTS];
    count_t t_stride [NUM_TESTS];

    string       test_name;
    bit          in_run;
    int          cur;
    int          exp_count;
    int          run_base;
    int          popped_total;
    int          test_errors;
    int          errors;
    int          failed_tests;
    int          cycle_count;
    int          cycle_limit;
    int          pop_mode;
    int          ready_hits;
    int          valid_hits;
    int          pause_hits;
    int          ready_base;
    int          valid_base;
    int          pause_base;
    int unsigned stim_seed;
    int unsigned pop_seed;

    always #5 ap_clk = ~ap_clk;

    serial_read_engine #(
        .FIFO_DEPTH       (32),
        .PROG_FULL_MARGIN (4),
        .ENGINE_ID        (TB_ENGINE_ID)
    ) uut (
        .ap_clk             (ap_clk),
        .engine_areset      (engine_areset),
        .cfg_valid          (cfg_valid),
        .cfg_array_pointer  (cfg_array_pointer),
        .cfg_start_read     (cfg_start_read),
        .cfg_end_read       (cfg_end_read),
        .cfg_stride         (cfg_stride),
        .start              (start),
        .ready              (ready),
        .done               (done),
        .pause              (pause),
        .req_valid          (req_valid),
        .req_pop            (req_pop),
        .req_cu_id          (req_cu_id),
        .req_base_address   (req_base_address),
        .req_address_offset (req_address_offset)
    );

    // -------------------------------------------------
    // Random source and reference model
    // -------------------------------------------------
    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int unsigned next_rand(input int unsigned span);
        stim_seed = lcg_next(stim_seed);
        return (stim_seed >> 8) % span;
    endfunction

    // k-th offset of the walk
    function automatic logic [63:0] ref_offset(input count_t first, input count_t step,
                                               input int k);
        return 64'(first) + 64'(k) * 64'(step);
    endfunction

    // Offsets strictly below the end offset
    function automatic int ref_count(input count_t first, input count_t last,
                                     input count_t step);
        longint unsigned span;
        if (step == '0 || last <= first) begin
            return 0;
        end
        span = 64'(last) - 64'(first);
        return int'((span + 64'(step) - 64'd1) / 64'(step));
    endfunction

    task automatic compare(input string what, input logic [63:0] expected,
                           input logic [63:0] actual);
        if (expected !== actual) begin
            $display("error %s: %s expected %0h actual %0h", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_request(input int k);
        if (k < exp_count) begin
            compare("cu_id", 64'(TB_ENGINE_ID), 64'(req_cu_id));
            compare("base address", 64'(t_ptr[cur]), 64'(req_base_address));
            compare("offset", ref_offset(t_start[cur], t_stride[cur], k),
                    64'(req_address_offset));
        end
    endtask

    // -------------------------------------------------
    // Run control
    // -------------------------------------------------
    task automatic start_run(input int idx, input string name);
        do @(negedge ap_clk); while (!ready);
        cur         = idx;
        test_name   = name;
        test_errors = 0;
        exp_count   = ref_count(t_start[idx], t_end[idx], t_stride[idx]);
        run_base    = popped_total;
        ready_base  = ready_hits;
        valid_base  = valid_hits;
        pause_base  = pause_hits;
        @(posedge ap_clk);
        #1;
        cfg_array_pointer = t_ptr[idx];
        cfg_start_read    = t_start[idx];
        cfg_end_read      = t_end[idx];
        cfg_stride        = t_stride[idx];
        cfg_valid         = 1'b1;
        start             = 1'b1;
        // Ready drops two edges after start
        repeat (2) @(posedge ap_clk);
        #1 in_run = 1'b1;
    endtask

    task automatic wait_done(input int hold_cycles);
        do @(negedge ap_clk); while (!done);
        while (req_valid) @(negedge ap_clk);
        repeat (hold_cycles) begin
            @(negedge ap_clk);
            compare("done while start held", 64'd1, 64'(done));
            compare("ready while start held", 64'd0, 64'(ready));
        end
    endtask

    task automatic end_run(input bit expect_pause, input bit expect_quiet);
        int received;
        @(posedge ap_clk);
        #1;
        cfg_valid = 1'b0;
        start     = 1'b0;
        in_run    = 1'b0;
        received  = popped_total - run_base;
        compare("request count", 64'(exp_count), 64'(received));
        compare("ready cycles during run", 64'd0, 64'(ready_hits - ready_base));
        if (expect_pause) begin
            compare("pause seen", 64'd1, 64'(pause_hits > pause_base));
        end else begin
            compare("pause cycles", 64'd0, 64'(pause_hits - pause_base));
        end
        if (expect_quiet) begin
            compare("req_valid cycles", 64'd0, 64'(valid_hits - valid_base));
        end
        errors += test_errors;
        if (test_errors != 0) begin
            failed_tests++;
        end
        $display("test %s: %s, %0d of %0d requests", test_name,
                 (test_errors == 0) ? "pass" : "fail", received, exp_count);
    endtask

    // -------------------------------------------------
    // Consumer and monitors
    // -------------------------------------------------
    initial begin
        req_pop      = 1'b0;
        pop_seed     = 32'd92;
        popped_total = 0;
        ready_hits   = 0;
        valid_hits   = 0;
        pause_hits   = 0;
        forever begin
            @(negedge ap_clk);
            if (in_run && ready) ready_hits++;
            if (in_run && req_valid) valid_hits++;
            if (in_run && pause) pause_hits++;
            // Head is taken on the coming edge
            if (req_valid === 1'b1 && req_pop) begin
                check_request(popped_total - run_base);
                popped_total++;
            end
            @(posedge ap_clk);
            #1;
            pop_seed = lcg_next(pop_seed);
            case (pop_mode)
                0:       req_pop = 1'b1;
                1:       req_pop = pop_seed[16];
                default: req_pop = 1'b0;
            endcase
        end
    end

    initial begin
        cycle_count = 0;
        do begin
            @(posedge ap_clk);
            cycle_count++;
        end while (cycle_count <= cycle_limit);
        $display("timeout after %0d cycles in test %s", cycle_count, test_name);
        $display("Done: errors found");
        $finish;
    end

    // -------------------------------------------------
    // Main sequence
    // -------------------------------------------------
    initial begin
        int i;
        engine_areset     = 1'b1;
        cfg_valid         = 1'b0;
        cfg_array_pointer = '0;
        cfg_start_read    = '0;
        cfg_end_read      = '0;
        cfg_stride        = '0;
        start             = 1'b0;
        in_run            = 1'b0;
        cur               = 0;
        run_base          = 0;
        exp_count         = 0;
        test_errors       = 0;
        errors            = 0;
        failed_tests      = 0;
        pop_mode          = 0;
        test_name         = "reset";
        stim_seed         = 32'd92;
        cycle_limit       = 0;

        for (i = 0; i < NUM_TESTS; i++) begin
            t_ptr[i]    = next_rand(65536) << 16;
            t_start[i]  = next_rand(64);
            t_stride[i] = 1 + next_rand(8);
            t_end[i]    = t_start[i] + 1 + next_rand(200);
        end
        // Long walk so the FIFO can fill
        t_stride[1] = 1 + next_rand(4);
        t_end[1]    = t_start[1] + t_stride[1] * (80 + next_rand(40));
        // End at or below start
        t_start[2]  = 100 + next_rand(100);
        t_end[2]    = t_start[2] - next_rand(8);
        t_stride[3] = '0;
        // Enough requests to outlast the mid-run descriptor change
        t_end[4]    = t_start[4] + t_stride[4] * (8 + next_rand(8));
        for (i = 0; i < NUM_TESTS; i++) begin
            cycle_limit += 4 * ref_count(t_start[i], t_end[i], t_stride[i]) + 200;
        end

        repeat (8) @(posedge ap_clk);
        #1 engine_areset = 1'b0;

        start_run(0, "basic");
        wait_done(0);
        end_run(1'b0, 1'b0);

        pop_mode = 1;
        start_run(1, "backpressure");
        repeat (20) @(posedge ap_clk);
        pop_mode = 2;
        repeat (60) @(posedge ap_clk);
        pop_mode = 1;
        wait_done(0);
        end_run(1'b1, 1'b0);
        pop_mode = 0;

        start_run(2, "empty_range");
        wait_done(0);
        end_run(1'b0, 1'b1);

        start_run(3, "zero_stride");
        wait_done(0);
        end_run(1'b0, 1'b1);

        // New descriptor on the inputs while the run is going
        start_run(4, "cfg_change");
        repeat (3) @(posedge ap_clk);
        #1;
        cfg_array_pointer = ~t_ptr[4];
        cfg_start_read    = t_start[4] + 32'd3;
        cfg_end_read      = t_end[4] + 32'd64;
        cfg_stride        = t_stride[4] + 32'd1;
        wait_done(0);
        end_run(1'b0, 1'b0);

        start_run(5, "hold_start");
        wait_done(10);
        end_run(1'b0, 1'b0);

        start_run(6, "second_run");
        wait_done(0);
        end_run(1'b0, 1'b0);

        $display("%0d tests, %0d failed, %0d errors", NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* list.f */
hw/serial_read_pkg.sv
hw/read_config_if.sv
hw/read_config_latch.sv
hw/read_sequencer.sv
hw/request_fifo.sv
hw/serial_read_engine.sv
bench/serial_read_engine_tb.sv

/* Makefile */
SIM       := verilator
TOP       := serial_read_engine_tb
FILELIST  := list.f
FLAGS     := --binary --timing --timescale 1ns/100ps --top-module $(TOP)
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
PASS_TEXT := Done: no errors
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
